// File: source/sched_pkg.sv
////////////////////
// Scheduler shared definitions
// Widths, vector types, port states and host register codes
////////////////////
package sched_pkg;

  localparam int CORE_ID_W = 2;
  // Slots count from 1, so a full pool of 8 needs the extra bit
  localparam int SLOT_W    = 4;
  localparam int DATA_W    = 32;

  typedef logic [CORE_ID_W-1:0]        core_id_t;
  typedef logic [SLOT_W-1:0]           slot_t;
  typedef logic [CORE_ID_W+SLOT_W-1:0] tag_t;
  typedef logic [DATA_W-1:0]           beat_t;

  typedef enum logic [1:0] {
    PS_STALL     = 2'b00,
    PS_READY     = 2'b01,
    PS_BUSY      = 2'b10,
    PS_BUSY_NEXT = 2'b11
  } port_state_t;

  // Slot control kinds
  localparam logic CTRL_RETURN = 1'b0;
  localparam logic CTRL_INIT   = 1'b1;

  // Host codes are cmd bit 30 joined with bits 3:0
  localparam logic [4:0] HOST_ENABLE  = 5'h00;
  localparam logic [4:0] HOST_INCOME  = 5'h01;
  localparam logic [4:0] HOST_FLUSH   = 5'h02;
  localparam logic [4:0] HOST_COUNT   = 5'h03;
  localparam logic [4:0] HOST_PORT    = 5'h10;
  localparam logic [4:0] HOST_RELEASE = 5'h12;

  localparam logic [31:0] HOST_DEFAULT_RD = 32'hFEFEFEFE;

endpackage

// File: source/slot_store.sv
////////////////////
// Slot store
// Free-slot FIFO of one core with init, return, pop and flush
////////////////////
`timescale 1ns/1ps

module slot_store import sched_pkg::*; #(
  parameter int SLOT_COUNT = 8
) (
  input  logic  clk,
  input  logic  rst_r,
  input  logic  flush,
  input  logic  init_valid,
  input  logic  ret_valid,
  input  slot_t ctrl_slot,
  input  logic  pop,
  output slot_t head,
  output slot_t count
);

  localparam int    PTR_W    = (SLOT_COUNT > 1) ? $clog2(SLOT_COUNT) : 1;
  localparam slot_t SLOT_MAX = slot_t'(SLOT_COUNT);

  slot_t            mem [SLOT_COUNT];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  slot_t            init_n;
  logic             full;
  logic             do_pop;
  logic             do_push;

  // Circular step that also wraps pool sizes that are not a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    if (p == PTR_W'(SLOT_COUNT - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  // An init larger than the pool loads the whole pool
  assign init_n  = (ctrl_slot > SLOT_MAX) ? SLOT_MAX : ctrl_slot;
  assign full    = (count == SLOT_MAX);
  assign do_pop  = pop && (count != '0) && !flush && !init_valid;
  // Returns into a full pool are dropped
  assign do_push = ret_valid && !full && !flush && !init_valid;

  assign head = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (rst_r || flush) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else if (init_valid) begin
      rd_ptr <= '0;
      wr_ptr <= (init_n == SLOT_MAX) ? '0 : PTR_W'(init_n);
      count  <= init_n;
    end else begin
      if (do_pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      if (do_push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  // Init writes slots 1..SLOT_COUNT, only the first N count as free
  always_ff @(posedge clk) begin
    if (init_valid && !flush) begin
      for (int i = 0; i < SLOT_COUNT; i++) begin
        mem[i] <= slot_t'(i + 1);
      end
    end else if (do_push) begin
      mem[wr_ptr] <= ctrl_slot;
    end
  end

endmodule

// File: source/core_picker.sv
////////////////////
// Core picker
// Grants tags from the core with most free slots, ports in round-robin
////////////////////
`timescale 1ns/1ps

module core_picker import sched_pkg::*; #(
  parameter int CORE_COUNT = 4,
  parameter int PORT_COUNT = 2
) (
  input  logic                  clk,
  input  logic                  rst_r,
  input  logic [CORE_COUNT-1:0] enabled_cores,
  input  logic [CORE_COUNT-1:0] income_cores,
  input  slot_t                 counts [CORE_COUNT],
  input  slot_t                 heads [CORE_COUNT],
  input  logic [PORT_COUNT-1:0] tag_req,
  output logic [PORT_COUNT-1:0] tag_ack,
  output tag_t                  tag_grant,
  output logic [CORE_COUNT-1:0] pop
);

  localparam int PORT_W = (PORT_COUNT > 1) ? $clog2(PORT_COUNT) : 1;

  typedef enum logic {
    PK_IDLE,
    PK_ACK
  } pick_state_t;

  pick_state_t       pick_state;
  logic [PORT_W-1:0] rr_ptr;
  logic [PORT_W-1:0] cur_port;
  logic [PORT_W-1:0] sel_port;
  logic              sel_port_v;
  core_id_t          sel_core;
  logic              sel_core_v;
  slot_t             best_cnt;

  // Largest count wins, strict compare keeps the lowest index on a tie
  always_comb begin : pick_core
    sel_core   = '0;
    sel_core_v = 1'b0;
    best_cnt   = '0;
    for (int c = 0; c < CORE_COUNT; c++) begin
      if (enabled_cores[c] && income_cores[c] && (counts[c] != '0) &&
          (!sel_core_v || (counts[c] > best_cnt))) begin
        sel_core   = core_id_t'(c);
        sel_core_v = 1'b1;
        best_cnt   = counts[c];
      end
    end
  end

  // First requesting port at or after the pointer
  always_comb begin : pick_port
    int idx;
    sel_port   = '0;
    sel_port_v = 1'b0;
    for (int i = 0; i < PORT_COUNT; i++) begin
      idx = (int'(rr_ptr) + i) % PORT_COUNT;
      if (!sel_port_v && tag_req[idx]) begin
        sel_port   = PORT_W'(idx);
        sel_port_v = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    pop <= '0;
    if (rst_r) begin
      pick_state <= PK_IDLE;
      tag_ack    <= '0;
      rr_ptr     <= '0;
      cur_port   <= '0;
    end else begin
      case (pick_state)
        PK_IDLE: begin
          if (sel_port_v && sel_core_v) begin
            pick_state        <= PK_ACK;
            tag_ack[sel_port] <= 1'b1;
            cur_port          <= sel_port;
            pop[sel_core]     <= 1'b1;
            tag_grant         <= {sel_core, heads[sel_core]};
            rr_ptr <= (sel_port == PORT_W'(PORT_COUNT - 1)) ? '0 : sel_port + 1'b1;
          end
        end
        PK_ACK: begin
          // Ack drops once the port has taken the tag and lowered req
          if (!tag_req[cur_port]) begin
            pick_state <= PK_IDLE;
            tag_ack    <= '0;
          end
        end
        default: pick_state <= PK_IDLE;
      endcase
    end
  end

endmodule

// File: source/port_tagger.sv
////////////////////
// Port tagger
// Gates one receive stream and stamps each packet with its tag
////////////////////
`timescale 1ns/1ps

module port_tagger import sched_pkg::*; (
  input  logic        clk,
  input  logic        rst_r,
  input  logic        tag_release,
  input  logic        rx_valid,
  input  logic        rx_last,
  input  beat_t       rx_data,
  input  logic        tx_ready,
  input  logic        tag_ack,
  input  tag_t        tag_grant,
  output logic        rx_ready,
  output logic        tx_valid,
  output logic        tx_last,
  output beat_t       tx_data,
  output tag_t        tx_tag,
  output logic        tag_req,
  output port_state_t state
);

  tag_t held_tag;
  tag_t pkt_tag;
  logic pass;
  logic beat;
  logic last_beat;
  logic want;
  logic got;

  assign pass      = (state != PS_STALL);
  assign tx_valid  = rx_valid && pass;
  assign rx_ready  = tx_ready && pass;
  assign tx_last   = rx_last;
  assign tx_data   = rx_data;
  // First beat uses the held tag directly, later beats the latched one
  assign tx_tag    = (state == PS_READY) ? held_tag : pkt_tag;

  assign beat      = rx_valid && rx_ready;
  assign last_beat = beat && rx_last;
  assign want      = (state == PS_STALL) || (state == PS_BUSY);
  assign got       = tag_req && tag_ack;

  always_ff @(posedge clk) begin
    if (rst_r) begin
      state   <= PS_STALL;
      tag_req <= 1'b0;
    end else begin
      case (state)
        PS_STALL: begin
          if (got) begin
            state <= PS_READY;
          end
        end
        PS_READY: begin
          if (last_beat) begin
            state <= PS_STALL;
          end else if (beat) begin
            state <= PS_BUSY;
          end else if (tag_release) begin
            state <= PS_STALL;
          end
        end
        PS_BUSY: begin
          if (got && last_beat) begin
            state <= PS_READY;
          end else if (got) begin
            state <= PS_BUSY_NEXT;
          end else if (last_beat) begin
            state <= PS_STALL;
          end
        end
        PS_BUSY_NEXT: begin
          if (last_beat) begin
            state <= tag_release ? PS_STALL : PS_READY;
          end else if (tag_release) begin
            // Next tag dropped, packet keeps going
            state <= PS_BUSY;
          end
        end
        default: state <= PS_STALL;
      endcase

      // A new req waits for the old ack to fall
      if (tag_req) begin
        if (tag_ack) begin
          tag_req <= 1'b0;
        end
      end else if (want && !tag_ack) begin
        tag_req <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (got) begin
      held_tag <= tag_grant;
    end
    if ((state == PS_READY) && beat) begin
      pkt_tag <= held_tag;
    end
  end

endmodule

// File: source/host_regs.sv
////////////////////
// Host registers
// Command decode, core masks, pulses and readback
////////////////////
`timescale 1ns/1ps

module host_regs import sched_pkg::*; #(
  parameter int CORE_COUNT = 4,
  parameter int PORT_COUNT = 2
) (
  input  logic                  clk,
  input  logic                  rst_r,
  input  logic                  host_cmd_valid,
  input  logic [31:0]           host_cmd,
  input  logic [31:0]           host_wr_data,
  input  slot_t                 counts [CORE_COUNT],
  input  port_state_t           port_states [PORT_COUNT],
  input  tag_t                  port_tags [PORT_COUNT],
  output logic [31:0]           host_rd_data,
  output logic [CORE_COUNT-1:0] enabled_cores,
  output logic [CORE_COUNT-1:0] income_cores,
  output logic [CORE_COUNT-1:0] flush,
  output logic [PORT_COUNT-1:0] tag_release
);

  logic        wr_r;
  logic [4:0]  code_r;
  core_id_t    sel_core_r;
  logic        sel_port_r;
  logic [31:0] wr_data_r;
  logic [31:0] rd_next;

  // Command stage
  always_ff @(posedge clk) begin
    code_r       <= {host_cmd[30], host_cmd[3:0]};
    sel_core_r   <= host_cmd[CORE_ID_W+3:4];
    sel_port_r   <= host_cmd[4];
    wr_data_r    <= host_wr_data;
    host_rd_data <= rd_next;
  end

  always_comb begin
    rd_next = HOST_DEFAULT_RD;
    case (code_r)
      HOST_ENABLE: rd_next = 32'(enabled_cores);
      HOST_INCOME: rd_next = 32'(income_cores);
      HOST_COUNT: begin
        if (int'(sel_core_r) < CORE_COUNT) begin
          rd_next = 32'(counts[sel_core_r]);
        end
      end
      HOST_PORT: begin
        if (int'(sel_port_r) < PORT_COUNT) begin
          rd_next                   = '0;
          rd_next[17:16]            = port_states[sel_port_r];
          rd_next[$bits(tag_t)-1:0] = port_tags[sel_port_r];
        end
      end
      default: rd_next = HOST_DEFAULT_RD;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      wr_r          <= 1'b0;
      enabled_cores <= '0;
      income_cores  <= '0;
      flush         <= '0;
      tag_release   <= '0;
    end else begin
      wr_r        <= host_cmd_valid && host_cmd[31] && host_cmd[29];
      flush       <= '0;
      tag_release <= '0;
      if (wr_r) begin
        case (code_r)
          HOST_ENABLE: begin
            // A disabled core cannot stay incoming
            enabled_cores <= wr_data_r[CORE_COUNT-1:0];
            income_cores  <= income_cores & wr_data_r[CORE_COUNT-1:0];
          end
          HOST_INCOME:  income_cores <= wr_data_r[CORE_COUNT-1:0] & enabled_cores;
          HOST_FLUSH:   flush <= wr_data_r[CORE_COUNT-1:0];
          HOST_RELEASE: tag_release <= wr_data_r[PORT_COUNT-1:0];
          default: ;
        endcase
      end
    end
  end

endmodule

// File: source/sched_top.sv
////////////////////
// Slot scheduler top level
// Slot stores, core picker, port taggers and host registers
////////////////////
`timescale 1ns/1ps

module sched_top import sched_pkg::*; #(
  parameter int CORE_COUNT = 4,
  parameter int SLOT_COUNT = 8,
  parameter int PORT_COUNT = 2
) (
  input  logic                  clk,
  input  logic                  rst_r,
  input  logic                  slot_ctrl_valid,
  input  logic                  slot_ctrl_kind,
  input  core_id_t              slot_ctrl_core,
  input  slot_t                 slot_ctrl_slot,
  input  logic [PORT_COUNT-1:0] rx_valid,
  output logic [PORT_COUNT-1:0] rx_ready,
  input  logic [PORT_COUNT-1:0] rx_last,
  input  beat_t                 rx_data [PORT_COUNT],
  output logic [PORT_COUNT-1:0] tx_valid,
  input  logic [PORT_COUNT-1:0] tx_ready,
  output logic [PORT_COUNT-1:0] tx_last,
  output beat_t                 tx_data [PORT_COUNT],
  output tag_t                  tx_tag [PORT_COUNT],
  input  logic                  host_cmd_valid,
  input  logic [31:0]           host_cmd,
  input  logic [31:0]           host_wr_data,
  output logic [31:0]           host_rd_data
);

  slot_t                 counts [CORE_COUNT];
  slot_t                 heads [CORE_COUNT];
  logic [CORE_COUNT-1:0] enabled_cores;
  logic [CORE_COUNT-1:0] income_cores;
  logic [CORE_COUNT-1:0] flush;
  logic [CORE_COUNT-1:0] pop;
  logic [CORE_COUNT-1:0] init_valid;
  logic [CORE_COUNT-1:0] ret_valid;
  logic [PORT_COUNT-1:0] tag_req;
  logic [PORT_COUNT-1:0] tag_ack;
  logic [PORT_COUNT-1:0] tag_release;
  tag_t                  tag_grant;
  port_state_t           port_states [PORT_COUNT];

  for (genvar c = 0; c < CORE_COUNT; c++) begin : g_core
    // Slot control is steered to its core by number
    assign init_valid[c] = slot_ctrl_valid && (slot_ctrl_kind == CTRL_INIT) &&
                           (slot_ctrl_core == core_id_t'(c));
    assign ret_valid[c]  = slot_ctrl_valid && (slot_ctrl_kind == CTRL_RETURN) &&
                           (slot_ctrl_core == core_id_t'(c));

    slot_store #(
      .SLOT_COUNT(SLOT_COUNT)
    ) u_slot_store (
      .clk       (clk),
      .rst_r     (rst_r),
      .flush     (flush[c]),
      .init_valid(init_valid[c]),
      .ret_valid (ret_valid[c]),
      .ctrl_slot (slot_ctrl_slot),
      .pop       (pop[c]),
      .head      (heads[c]),
      .count     (counts[c])
    );
  end

  core_picker #(
    .CORE_COUNT(CORE_COUNT),
    .PORT_COUNT(PORT_COUNT)
  ) u_core_picker (
    .clk          (clk),
    .rst_r        (rst_r),
    .enabled_cores(enabled_cores),
    .income_cores (income_cores),
    .counts       (counts),
    .heads        (heads),
    .tag_req      (tag_req),
    .tag_ack      (tag_ack),
    .tag_grant    (tag_grant),
    .pop          (pop)
  );

  for (genvar p = 0; p < PORT_COUNT; p++) begin : g_port
    port_tagger u_port_tagger (
      .clk        (clk),
      .rst_r      (rst_r),
      .tag_release(tag_release[p]),
      .rx_valid   (rx_valid[p]),
      .rx_last    (rx_last[p]),
      .rx_data    (rx_data[p]),
      .tx_ready   (tx_ready[p]),
      .tag_ack    (tag_ack[p]),
      .tag_grant  (tag_grant),
      .rx_ready   (rx_ready[p]),
      .tx_valid   (tx_valid[p]),
      .tx_last    (tx_last[p]),
      .tx_data    (tx_data[p]),
      .tx_tag     (tx_tag[p]),
      .tag_req    (tag_req[p]),
      .state      (port_states[p])
    );
  end

  host_regs #(
    .CORE_COUNT(CORE_COUNT),
    .PORT_COUNT(PORT_COUNT)
  ) u_host_regs (
    .clk           (clk),
    .rst_r         (rst_r),
    .host_cmd_valid(host_cmd_valid),
    .host_cmd      (host_cmd),
    .host_wr_data  (host_wr_data),
    .counts        (counts),
    .port_states   (port_states),
    .port_tags     (tx_tag),
    .host_rd_data  (host_rd_data),
    .enabled_cores (enabled_cores),
    .income_cores  (income_cores),
    .flush         (flush),
    .tag_release   (tag_release)
  );

endmodule

// File: verification/tb_sched.sv
////////////////////
// Slot scheduler testbench
// Directed tests against a model of the per-core slot pools
////////////////////
`timescale 1ns/1ps

module tb_sched import sched_pkg::*; ();

  localparam int CLK_PERIOD = 20;
  // About a dozen short packets plus host traffic, with a wide margin
  localparam int MAX_CYCLES = 4000;

  logic        clk;
  logic        rst_r;
  logic        slot_ctrl_valid;
  logic        slot_ctrl_kind;
  core_id_t    slot_ctrl_core;
  slot_t       slot_ctrl_slot;
  logic [1:0]  rx_valid;
  logic [1:0]  rx_ready;
  logic [1:0]  rx_last;
  beat_t       rx_data [2];
  logic [1:0]  tx_valid;
  logic [1:0]  tx_ready;
  logic [1:0]  tx_last;
  beat_t       tx_data [2];
  tag_t        tx_tag [2];
  logic        host_cmd_valid;
  logic [31:0] host_cmd;
  logic [31:0] host_wr_data;
  logic [31:0] host_rd_data;

  // Model of the per-core free-slot FIFOs
  int          pool_mem [4][8];
  int          pool_head [4];
  int          pool_cnt [4];
  logic [3:0]  model_enable;
  logic [3:0]  model_income;

  logic [31:0] rng_state;
  int          cycles;
  int          errors;
  int          tests_run;
  int          tests_failed;
  logic [1:0]  ports_done;
  tag_t        port1_tag;
  tag_t        grants [8];
  tag_t        used [6];

  sched_top u_dut (
    .clk            (clk),
    .rst_r          (rst_r),
    .slot_ctrl_valid(slot_ctrl_valid),
    .slot_ctrl_kind (slot_ctrl_kind),
    .slot_ctrl_core (slot_ctrl_core),
    .slot_ctrl_slot (slot_ctrl_slot),
    .rx_valid       (rx_valid),
    .rx_ready       (rx_ready),
    .rx_last        (rx_last),
    .rx_data        (rx_data),
    .tx_valid       (tx_valid),
    .tx_ready       (tx_ready),
    .tx_last        (tx_last),
    .tx_data        (tx_data),
    .tx_tag         (tx_tag),
    .host_cmd_valid (host_cmd_valid),
    .host_cmd       (host_cmd),
    .host_wr_data   (host_wr_data),
    .host_rd_data   (host_rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run stopped after %0d cycles", MAX_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Write flag in bits 31 and 29, code in bit 30 and 3:0, select in 5:4
  function automatic logic [31:0] make_cmd(input logic wr, input logic [4:0] code,
                                           input int sel);
    logic [31:0] cmd;
    cmd      = '0;
    cmd[31]  = wr;
    cmd[30]  = code[4];
    cmd[29]  = wr;
    cmd[5:4] = sel[1:0];
    cmd[3:0] = code[3:0];
    return cmd;
  endfunction

  task automatic load_pool(input int c, input int n);
    pool_head[c] = 0;
    pool_cnt[c]  = n;
    for (int i = 0; i < 8; i++) begin
      pool_mem[c][i] = i + 1;
    end
  endtask

  task automatic push_pool(input int c, input int s);
    if (pool_cnt[c] < 8) begin
      pool_mem[c][(pool_head[c] + pool_cnt[c]) % 8] = s;
      pool_cnt[c]++;
    end
  endtask

  // Most free slots wins, lowest core on a tie
  function automatic tag_t pick_tag();
    int   best;
    tag_t t;
    best = -1;
    for (int c = 0; c < 4; c++) begin
      if (model_enable[c] && model_income[c] && (pool_cnt[c] > 0) &&
          ((best < 0) || (pool_cnt[c] > pool_cnt[best]))) begin
        best = c;
      end
    end
    t            = {core_id_t'(best), slot_t'(pool_mem[best][pool_head[best]])};
    pool_head[best] = (pool_head[best] + 1) % 8;
    pool_cnt[best]--;
    return t;
  endfunction

  function automatic int grant_hits(input tag_t t);
    int n;
    n = 0;
    for (int k = 0; k < 8; k++) begin
      if (grants[k] === t) begin
        n++;
      end
    end
    return n;
  endfunction

  function automatic int use_hits(input tag_t t);
    int n;
    n = 0;
    for (int k = 0; k < 6; k++) begin
      if (used[k] === t) begin
        n++;
      end
    end
    return n;
  endfunction

  task automatic write_reg(input logic [4:0] code, input int sel, input logic [31:0] data);
    @(negedge clk);
    host_cmd_valid = 1'b1;
    host_cmd       = make_cmd(1'b1, code, sel);
    host_wr_data   = data;
    @(negedge clk);
    host_cmd_valid = 1'b0;
    host_cmd       = '0;
    @(negedge clk);
  endtask

  // Read data arrives two cycles after the command cycle
  task automatic read_reg(input logic [4:0] code, input int sel, output logic [31:0] data);
    @(negedge clk);
    host_cmd = make_cmd(1'b0, code, sel);
    @(negedge clk);
    @(negedge clk);
    data     = host_rd_data;
    host_cmd = '0;
  endtask

  task automatic send_ctrl(input logic kind, input int core, input int slot);
    @(negedge clk);
    slot_ctrl_valid = 1'b1;
    slot_ctrl_kind  = kind;
    slot_ctrl_core  = core_id_t'(core);
    slot_ctrl_slot  = slot_t'(slot);
    @(negedge clk);
    slot_ctrl_valid = 1'b0;
  endtask

  // Beats are checked in the low clock phase, before the edge that moves them
  task automatic send_packet(input int p, input int len, output tag_t tag);
    beat_t data;
    for (int b = 0; b < len; b++) begin
      data = next_rand();
      @(negedge clk);
      rx_valid[p] = 1'b1;
      rx_last[p]  = (b == len - 1);
      rx_data[p]  = data;
      #1;
      while (!rx_ready[p]) begin
        @(negedge clk);
        #1;
      end
      if (b == 0) begin
        tag = tx_tag[p];
      end
      if (!tx_valid[p] || (tx_data[p] !== data) || (tx_last[p] !== (b == len - 1)) ||
          (tx_tag[p] !== tag)) begin
        $display("mismatch at %0t: port %0d beat %0d data %h tag %h, expected %h tag %h",
                 $time, p, b, tx_data[p], tx_tag[p], data, tag);
        errors++;
      end
    end
    @(negedge clk);
    rx_valid[p] = 1'b0;
    rx_last[p]  = 1'b0;
  endtask

  task automatic wait_ports_ready(input logic [1:0] mask);
    @(negedge clk);
    #1;
    while ((rx_ready & mask) != mask) begin
      @(negedge clk);
      #1;
    end
  endtask

  task automatic send_burst(input int p);
    tag_t got;
    for (int k = 0; k < 3; k++) begin
      send_packet(p, 1 + int'(next_rand() % 32'd4), got);
      used[p * 3 + k] = got;
    end
    ports_done[p] = 1'b1;
  endtask

  task automatic drive_backpressure();
    logic [31:0] r;
    while (ports_done != 2'b11) begin
      @(negedge clk);
      r        = next_rand();
      tx_ready = r[1:0];
    end
    tx_ready = 2'b11;
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("%s: pass", name);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, errors - errs_before);
    end
  endtask

  task automatic check_reset_state();
    int          e0;
    logic [31:0] rd;
    e0 = errors;
    @(negedge clk);
    rx_valid = 2'b11;
    repeat (4) begin
      #1;
      if ((rx_ready !== 2'b00) || (tx_valid !== 2'b00)) begin
        $display("mismatch at %0t: rx_ready %b tx_valid %b, expected 00", $time,
                 rx_ready, tx_valid);
        errors++;
      end
      @(negedge clk);
    end
    rx_valid = 2'b00;
    read_reg(HOST_ENABLE, 0, rd);
    if (rd !== 32'h0) begin
      $display("mismatch at %0t: enable mask %h, expected 0", $time, rd);
      errors++;
    end
    for (int c = 0; c < 4; c++) begin
      read_reg(HOST_COUNT, c, rd);
      if (rd !== 32'h0) begin
        $display("mismatch at %0t: core %0d count %h, expected 0", $time, c, rd);
        errors++;
      end
    end
    end_test("reset state", e0);
  endtask

  task automatic check_register_rules();
    int          e0;
    logic [31:0] rd;
    e0 = errors;
    write_reg(HOST_ENABLE, 0, 32'h7);
    write_reg(HOST_INCOME, 0, 32'hF);
    model_enable = 4'b0111;
    model_income = 4'b0111;
    read_reg(HOST_INCOME, 0, rd);
    if (rd !== 32'h7) begin
      $display("mismatch at %0t: income mask %h, expected 7", $time, rd);
      errors++;
    end
    read_reg(HOST_ENABLE, 0, rd);
    if (rd !== 32'h7) begin
      $display("mismatch at %0t: enable mask %h, expected 7", $time, rd);
      errors++;
    end
    read_reg(5'h05, 0, rd);
    if (rd !== HOST_DEFAULT_RD) begin
      $display("mismatch at %0t: unknown register %h, expected %h", $time, rd,
               HOST_DEFAULT_RD);
      errors++;
    end
    end_test("register rules", e0);
  endtask

  task automatic tag_single_port();
    int   e0;
    tag_t expect_tag;
    tag_t got;
    e0 = errors;
    // Income off so both pools are loaded before the first grant
    write_reg(HOST_INCOME, 0, 32'h0);
    model_income = 4'b0000;
    send_ctrl(CTRL_INIT, 0, 2);
    send_ctrl(CTRL_INIT, 1, 3);
    load_pool(0, 2);
    load_pool(1, 3);
    write_reg(HOST_INCOME, 0, 32'h7);
    model_income = 4'b0111;
    // Round-robin serves port 0 first, port 1 then holds one tag
    expect_tag = pick_tag();
    port1_tag  = pick_tag();
    wait_ports_ready(2'b11);
    for (int k = 0; k < 4; k++) begin
      send_packet(0, 1 + int'(next_rand() % 32'd6), got);
      if (got !== expect_tag) begin
        $display("mismatch at %0t: packet %0d tag %h, expected %h", $time, k, got,
                 expect_tag);
        errors++;
      end
      if (k < 3) begin
        expect_tag = pick_tag();
      end
    end
    end_test("single port tagging", e0);
  endtask

  task automatic starve_and_return();
    int   e0;
    tag_t expect_tag;
    tag_t got;
    e0 = errors;
    @(negedge clk);
    rx_valid[0] = 1'b1;
    rx_last[0]  = 1'b1;
    rx_data[0]  = next_rand();
    repeat (8) begin
      #1;
      if (rx_ready[0] || tx_valid[0]) begin
        $display("mismatch at %0t: port 0 passes a beat with no slot left", $time);
        errors++;
      end
      @(negedge clk);
    end
    rx_valid[0] = 1'b0;
    rx_last[0]  = 1'b0;
    send_ctrl(CTRL_RETURN, 1, 2);
    push_pool(1, 2);
    expect_tag = pick_tag();
    send_packet(0, 1 + int'(next_rand() % 32'd6), got);
    if (got !== expect_tag) begin
      $display("mismatch at %0t: returned slot tag %h, expected %h", $time, got, expect_tag);
      errors++;
    end
    end_test("starvation", e0);
  endtask

  task automatic run_two_ports();
    int          e0;
    tag_t        got;
    logic [31:0] rd;
    e0 = errors;
    send_packet(1, 3, got);
    if (got !== port1_tag) begin
      $display("mismatch at %0t: port 1 held tag %h, expected %h", $time, got, port1_tag);
      errors++;
    end
    write_reg(HOST_INCOME, 0, 32'h0);
    model_income = 4'b0000;
    send_ctrl(CTRL_INIT, 0, 3);
    send_ctrl(CTRL_INIT, 1, 4);
    send_ctrl(CTRL_INIT, 2, 3);
    send_ctrl(CTRL_INIT, 3, 8);
    load_pool(0, 3);
    load_pool(1, 4);
    load_pool(2, 3);
    load_pool(3, 8);
    write_reg(HOST_INCOME, 0, 32'h7);
    model_income = 4'b0111;
    // Six packets plus one prefetched tag per port use eight grants
    for (int k = 0; k < 8; k++) begin
      grants[k] = pick_tag();
    end
    ports_done = 2'b00;
    fork
      send_burst(0);
      send_burst(1);
      drive_backpressure();
    join
    wait_ports_ready(2'b11);
    for (int i = 0; i < 6; i++) begin
      if ((use_hits(used[i]) != 1) || (grant_hits(used[i]) != 1)) begin
        $display("mismatch at %0t: tag %h is repeated or was never granted", $time, used[i]);
        errors++;
      end
    end
    for (int c = 0; c < 4; c++) begin
      read_reg(HOST_COUNT, c, rd);
      if (rd !== 32'(pool_cnt[c])) begin
        $display("mismatch at %0t: core %0d count %0d, expected %0d", $time, c, rd,
                 pool_cnt[c]);
        errors++;
      end
    end
    end_test("two ports with back-pressure", e0);
  endtask

  task automatic flush_and_release();
    int          e0;
    logic [31:0] rd;
    tag_t        held [2];
    e0 = errors;
    for (int p = 0; p < 2; p++) begin
      read_reg(HOST_PORT, p, rd);
      held[p] = rd[$bits(tag_t)-1:0];
      if ((rd[17:16] !== PS_READY) || (grant_hits(held[p]) != 1) ||
          (use_hits(held[p]) != 0)) begin
        $display("mismatch at %0t: port %0d status %h, expected a ready unused tag", $time,
                 p, rd);
        errors++;
      end
    end
    if (held[0] === held[1]) begin
      $display("mismatch at %0t: both ports hold the same tag %h", $time, held[0]);
      errors++;
    end
    // No new grants, so a released port stays stalled
    write_reg(HOST_INCOME, 0, 32'h0);
    model_income = 4'b0000;
    write_reg(HOST_RELEASE, 0, 32'h1);
    read_reg(HOST_PORT, 0, rd);
    if (rd[17:16] !== PS_STALL) begin
      $display("mismatch at %0t: released port 0 state %b, expected stall", $time, rd[17:16]);
      errors++;
    end
    read_reg(HOST_PORT, 1, rd);
    if (rd[17:16] !== PS_READY) begin
      $display("mismatch at %0t: port 1 state %b, expected ready", $time, rd[17:16]);
      errors++;
    end
    write_reg(HOST_FLUSH, 0, 32'hC);
    pool_cnt[2] = 0;
    pool_cnt[3] = 0;
    for (int c = 0; c < 4; c++) begin
      read_reg(HOST_COUNT, c, rd);
      if (rd !== 32'(pool_cnt[c])) begin
        $display("mismatch at %0t: core %0d count %0d after flush, expected %0d", $time, c,
                 rd, pool_cnt[c]);
        errors++;
      end
    end
    end_test("flush and release", e0);
  endtask

  initial begin
    rst_r           = 1'b1;
    slot_ctrl_valid = 1'b0;
    slot_ctrl_kind  = CTRL_RETURN;
    slot_ctrl_core  = '0;
    slot_ctrl_slot  = '0;
    rx_valid        = 2'b00;
    rx_last         = 2'b00;
    rx_data[0]      = '0;
    rx_data[1]      = '0;
    tx_ready        = 2'b11;
    host_cmd_valid  = 1'b0;
    host_cmd        = '0;
    host_wr_data    = '0;
    rng_state       = 32'h484f;
    errors          = 0;
    tests_run       = 0;
    tests_failed    = 0;
    ports_done      = 2'b00;
    model_enable    = 4'b0000;
    model_income    = 4'b0000;
    for (int c = 0; c < 4; c++) begin
      load_pool(c, 0);
    end

    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_r = 1'b0;

    check_reset_state();
    check_register_rules();
    tag_single_port();
    starve_and_return();
    run_two_ports();
    flush_and_release();

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: scheduler_lite.f
source/sched_pkg.sv
source/slot_store.sv
source/core_picker.sv
source/port_tagger.sv
source/host_regs.sv
source/sched_top.sv
verification/tb_sched.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_sched
FILELIST  ?= scheduler_lite.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)
